// ==== files.f ====
design/video_pkg.sv
design/video_timing.sv
design/square_sprite.sv
design/pixel_composer.sv
design/bridge_regs.sv
design/core_top.sv
verif/core_top_asserts.sv
verif/tb_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module tb_core_top -f files.f \
    --Mdir "$BUILD_DIR" -o tb_core_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_core_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== verif/tb_core_top.sv ====
// testbench for the video test-pattern core
// small raster, bridge border writes, random d-pad and face keys,
// every active pixel compared against a reference model

`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    import video_pkg::*;

    // small raster of 1200 clocks per frame
    localparam int H_BPORCH      = 4;
    localparam int H_ACTIVE      = 24;
    localparam int H_TOTAL       = 40;
    localparam int V_BPORCH      = 3;
    localparam int V_ACTIVE      = 18;
    localparam int V_TOTAL       = 30;
    localparam int SQUARE_SIZE   = 6;
    localparam int X_MAX         = H_ACTIVE - SQUARE_SIZE;
    localparam int Y_MAX         = V_ACTIVE - SQUARE_SIZE;

    localparam int RAND_SEGMENTS = 12;
    localparam int RAND_HOLD     = 3;
    localparam int CLAMP_FRAMES  = 20;
    // one vsync per start_frame call
    localparam int NUM_FRAMES    = 5 + RAND_SEGMENTS * RAND_HOLD + 2 * CLAMP_FRAMES + 5;
    localparam int TIMEOUT_NS    = (NUM_FRAMES + 4) * V_TOTAL * H_TOTAL * 20;

    logic        clk_74a;
    logic        reset_n;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic [31:0] bridge_rd_data;
    key_t        cont1_key;
    rgb_t        video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    // reference model state
    int          model_x = (H_ACTIVE - SQUARE_SIZE) / 2;
    int          model_y = (V_ACTIVE - SQUARE_SIZE) / 2;
    logic        border_model;
    logic [16:0] lfsr;

    // compare process state
    int          pix_x = 0;
    int          pix_y = 0;
    int          hs_count = 0;
    int          cycle_count = 0;
    int          frames_seen = 0;
    logic        de_prev = 1'b0;
    rgb_t        expected_rgb;

    // last black pixel of a frame is the square's bottom right corner
    int          black_x = 0;
    int          black_y = 0;
    // square corner as drawn in the last complete frame
    int          drawn_x = 0;
    int          drawn_y = 0;

    int          pixel_errors = 0;
    int          timing_errors = 0;
    int          stim_errors = 0;

    core_top #(
        .H_BPORCH    (H_BPORCH),
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_BPORCH    (V_BPORCH),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .SQUARE_SIZE (SQUARE_SIZE)
    ) DUT (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .cont1_key      (cont1_key),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

    always #10 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////
    // reference model

    // x^17 + x^14 + 1 shifting toward the msb
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic take_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
    endtask

    // expected colour at visible x/y
    function automatic rgb_t expected_pixel(input int x, input int y, input int sx,
                                            input int sy, input logic border,
                                            input key_t keys);
        rgb_t       pix;
        logic [7:0] r;
        logic [7:0] g;
        r = x[7:0];
        g = y[7:0];
        pix = {r, g, r ^ g};
        if (border) begin
            if (x == 0) begin
                pix = COLOR_WHITE;
            end else if (x == H_ACTIVE - 1) begin
                pix = COLOR_GREEN;
            end else if (y == 0) begin
                pix = COLOR_RED;
            end else if (y == V_ACTIVE - 1) begin
                pix = COLOR_BLUE;
            end
        end
        if (x >= sx && x < sx + SQUARE_SIZE && y >= sy && y < sy + SQUARE_SIZE) begin
            // outermost row or column of the square
            if (x == sx || y == sy || x == sx + SQUARE_SIZE - 1 || y == sy + SQUARE_SIZE - 1) begin
                pix = COLOR_BLACK;
            end else if (keys[KEY_FACE_A]) begin
                pix = COLOR_MAGENTA;
            end else if (keys[KEY_FACE_B]) begin
                pix = COLOR_GREEN;
            end else begin
                pix = COLOR_WHITE;
            end
        end
        return pix;
    endfunction

    // one move per frame with each direction judged from the old corner
    task step_square(input key_t key_set);
        int new_x;
        int new_y;
        new_x = model_x;
        new_y = model_y;
        if (key_set[KEY_UP] && model_y > 0) begin
            new_y = new_y - 1;
        end
        if (key_set[KEY_DOWN] && model_y < Y_MAX) begin
            new_y = new_y + 1;
        end
        if (key_set[KEY_LEFT] && model_x > 0) begin
            new_x = new_x - 1;
        end
        if (key_set[KEY_RIGHT] && model_x < X_MAX) begin
            new_x = new_x + 1;
        end
        model_x = new_x;
        model_y = new_y;
    endtask

    ////////////////////////////////////////////////////////////
    // compare process sampling mid-cycle

    always @(negedge clk_74a) begin
        if (reset_n) begin
            cycle_count++;
            if (video_hs && video_vs) begin
                $display("ERROR video_hs %h video_vs %h high together", video_hs, video_vs);
                timing_errors++;
            end
            if (!video_de && video_rgb != COLOR_BLACK) begin
                $display("ERROR video_rgb in blanking: got %06h, expected %06h",
                         video_rgb, COLOR_BLACK);
                timing_errors++;
            end
            if (video_hs) begin
                hs_count++;
            end
            if (video_de) begin
                expected_rgb = expected_pixel(pix_x, pix_y, model_x, model_y,
                                              border_model, cont1_key);
                if (video_rgb !== expected_rgb) begin
                    $display("ERROR video_rgb at x %0d y %0d: got %06h, expected %06h",
                             pix_x, pix_y, video_rgb, expected_rgb);
                    pixel_errors++;
                end
                if (video_rgb === COLOR_BLACK) begin
                    black_x = pix_x;
                    black_y = pix_y;
                end
                pix_x++;
            end else if (de_prev) begin
                // falling de closes a line
                if (pix_x != H_ACTIVE) begin
                    $display("ERROR video_de pixels per line: got %0h, expected %0h",
                             pix_x, H_ACTIVE);
                    timing_errors++;
                end
                pix_x = 0;
                pix_y++;
            end
            de_prev = video_de;
            if (video_vs) begin
                if (frames_seen > 0) begin
                    if (pix_y != V_ACTIVE) begin
                        $display("ERROR video_de lines per frame: got %0h, expected %0h",
                                 pix_y, V_ACTIVE);
                        timing_errors++;
                    end
                    if (hs_count != V_TOTAL) begin
                        $display("ERROR video_hs pulses per frame: got %0h, expected %0h",
                                 hs_count, V_TOTAL);
                        timing_errors++;
                    end
                    if (cycle_count != V_TOTAL * H_TOTAL) begin
                        $display("ERROR video_vs period: got %0h, expected %0h",
                                 cycle_count, V_TOTAL * H_TOTAL);
                        timing_errors++;
                    end
                end
                drawn_x = black_x - (SQUARE_SIZE - 1);
                drawn_y = black_y - (SQUARE_SIZE - 1);
                frames_seen++;
                pix_y = 0;
                hs_count = 0;
                cycle_count = 0;
                // position register loads at the coming edge
                step_square(cont1_key);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    task tick();
        @(posedge clk_74a);
        #2;
    endtask

    // sync to vsync and then set new keys in the top blanking lines
    task start_frame(input key_t key_set);
        tick();
        while (video_vs !== 1'b1) begin
            tick();
        end
        repeat (10) tick();
        cont1_key = key_set;
    endtask

    task write_border(input logic value);
        bridge_addr    = BORDER_REG_ADDR;
        bridge_wr_data = {31'b0, value};
        bridge_wr      = 1'b1;
        tick();
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        border_model   = value;
    endtask

    task check_read(input logic [31:0] addr, input logic [31:0] expected);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        if (bridge_rd_data !== expected) begin
            $display("ERROR bridge_rd_data at %08h: got %08h, expected %08h",
                     addr, bridge_rd_data, expected);
            stim_errors++;
        end
        tick();
        bridge_rd   = 1'b0;
        bridge_addr = '0;
    endtask

    task print_counts();
        $display("pixel errors %0d, timing errors %0d, stimulus errors %0d",
                 pixel_errors, timing_errors, stim_errors);
    endtask

    initial begin
        key_t        keys;
        logic [15:0] bits;

        clk_74a        = 1'b0;
        reset_n        = 1'b0;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        cont1_key      = '0;
        lfsr           = 17'd85480;
        border_model   = 1'b1;

        repeat (2) @(posedge clk_74a);
        #2;
        if (video_de || video_hs || video_vs || video_rgb != COLOR_BLACK) begin
            $display("ERROR video outputs in reset: de %h hs %h vs %h rgb %06h",
                     video_de, video_hs, video_vs, video_rgb);
            stim_errors++;
        end
        reset_n = 1'b1;

        // border on out of reset and other addresses read zero
        start_frame('0);
        check_read(BORDER_REG_ADDR, 32'h1);
        check_read(BORDER_REG_ADDR + 32'h4, 32'h0);
        check_read(32'h0, 32'h0);
        // plain pattern frames
        start_frame('0);
        write_border(1'b0);
        check_read(BORDER_REG_ADDR, 32'h0);
        start_frame('0);
        // border back on for one frame
        start_frame('0);
        write_border(1'b1);
        check_read(BORDER_REG_ADDR, 32'h1);
        start_frame('0);
        write_border(1'b0);
        check_read(BORDER_REG_ADDR, 32'h0);

        // random d-pad and face keys held a few frames each
        for (int seg = 0; seg < RAND_SEGMENTS; seg++) begin
            take_bits(6, bits);
            for (int f = 0; f < RAND_HOLD; f++) begin
                start_frame(bits);
            end
        end

        // drive into the bottom right limit
        keys = '0;
        keys[KEY_RIGHT] = 1'b1;
        keys[KEY_DOWN]  = 1'b1;
        repeat (CLAMP_FRAMES) start_frame(keys);
        if (drawn_x != X_MAX || drawn_y != Y_MAX) begin
            $display("ERROR video_rgb square corner: got x %0h y %0h, expected x %0h y %0h",
                     drawn_x, drawn_y, X_MAX, Y_MAX);
            stim_errors++;
        end
        // and back to the top left
        keys = '0;
        keys[KEY_LEFT] = 1'b1;
        keys[KEY_UP]   = 1'b1;
        repeat (CLAMP_FRAMES) start_frame(keys);
        if (drawn_x != 0 || drawn_y != 0) begin
            $display("ERROR video_rgb square corner: got x %0h y %0h, expected x %0h y %0h",
                     drawn_x, drawn_y, 0, 0);
            stim_errors++;
        end

        // fill colours for A alone, B alone and both
        keys = '0;
        keys[KEY_FACE_A] = 1'b1;
        start_frame(keys);
        keys = '0;
        keys[KEY_FACE_B] = 1'b1;
        start_frame(keys);
        keys[KEY_FACE_A] = 1'b1;
        start_frame(keys);
        start_frame('0);
        // last vsync closes the previous frame
        start_frame('0);

        if (frames_seen != NUM_FRAMES) begin
            $display("ERROR wrong number of frames seen, %0d instead of %0d",
                     frames_seen, NUM_FRAMES);
            stim_errors++;
        end
        print_counts();
        if (pixel_errors + timing_errors + stim_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("ERROR timeout after %0d of %0d frames", frames_seen, NUM_FRAMES);
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/core_top_asserts.sv ====
// video output checks bound into the core top level
// sync pulses apart, black in blanking, single-clock vsync

`timescale 1ns/1ps
`default_nettype none

module core_top_asserts (
    input wire              clk_74a,
    input wire              reset_n,
    input video_pkg::rgb_t  video_rgb,
    input wire              video_de,
    input wire              video_hs,
    input wire              video_vs
);

    // hsync sits a few clocks into the line, vsync at x 0
    sync_apart: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !(video_hs && video_vs))
        else $error("video_hs and video_vs high in the same clock");

    // composer forces black outside the window
    blank_black: assert property (@(posedge clk_74a) disable iff (!reset_n)
        !video_de |-> (video_rgb == '0))
        else $error("video_rgb not black while video_de is low");

    // one clock per frame
    vs_single: assert property (@(posedge clk_74a) disable iff (!reset_n)
        video_vs |=> !video_vs)
        else $error("video_vs longer than one clock");

endmodule

bind core_top core_top_asserts u_core_top_asserts (
    .clk_74a   (clk_74a),
    .reset_n   (reset_n),
    .video_rgb (video_rgb),
    .video_de  (video_de),
    .video_hs  (video_hs),
    .video_vs  (video_vs)
);

`default_nettype wire

// ==== design/core_top.sv ====
// video test-pattern core top level
// timing, square sprite, pixel composer and bridge registers
// all on clk_74a

`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter int H_BPORCH    = video_pkg::DEF_H_BPORCH,
    parameter int H_ACTIVE    = video_pkg::DEF_H_ACTIVE,
    parameter int H_TOTAL     = video_pkg::DEF_H_TOTAL,
    parameter int V_BPORCH    = video_pkg::DEF_V_BPORCH,
    parameter int V_ACTIVE    = video_pkg::DEF_V_ACTIVE,
    parameter int V_TOTAL     = video_pkg::DEF_V_TOTAL,
    parameter int SQUARE_SIZE = video_pkg::DEF_SQUARE_SIZE
) (
    input  wire                 clk_74a,
    input  wire                 reset_n,

    // bridge bus
    input  wire  [31:0]         bridge_addr,
    input  wire                 bridge_rd,
    input  wire                 bridge_wr,
    input  wire  [31:0]         bridge_wr_data,
    output logic [31:0]         bridge_rd_data,

    // controller 1
    input  video_pkg::key_t     cont1_key,

    // video to scaler
    output video_pkg::rgb_t     video_rgb,
    output logic                video_de,
    output logic                video_hs,
    output logic                video_vs
);

    import video_pkg::*;

    // counter stage
    logic   active;
    coord_t visible_x;
    coord_t visible_y;
    logic   frame_start;

    // sprite hit and colour
    logic   square_edge;
    logic   square_fill;
    rgb_t   fill_rgb;

    logic   border_en;

    ////////////////////////////////////////////////////////////
    // video path

    video_timing #(
        .H_BPORCH   (H_BPORCH),
        .H_ACTIVE   (H_ACTIVE),
        .H_TOTAL    (H_TOTAL),
        .V_BPORCH   (V_BPORCH),
        .V_ACTIVE   (V_ACTIVE),
        .V_TOTAL    (V_TOTAL)
    ) u_video_timing (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .visible_x   (visible_x),
        .visible_y   (visible_y),
        .active      (active),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .frame_start (frame_start)
    );

    square_sprite #(
        .H_ACTIVE    (H_ACTIVE),
        .V_ACTIVE    (V_ACTIVE),
        .SQUARE_SIZE (SQUARE_SIZE)
    ) u_square_sprite (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .cont1_key   (cont1_key),
        .frame_start (frame_start),
        .visible_x   (visible_x),
        .visible_y   (visible_y),
        .square_edge (square_edge),
        .square_fill (square_fill),
        .fill_rgb    (fill_rgb)
    );

    pixel_composer #(
        .H_ACTIVE   (H_ACTIVE),
        .V_ACTIVE   (V_ACTIVE)
    ) u_pixel_composer (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .active      (active),
        .border_en   (border_en),
        .square_edge (square_edge),
        .square_fill (square_fill),
        .visible_x   (visible_x),
        .visible_y   (visible_y),
        .fill_rgb    (fill_rgb),
        .video_rgb   (video_rgb)
    );

    ////////////////////////////////////////////////////////////
    // host side

    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .border_en      (border_en)
    );

endmodule

`default_nettype wire

// ==== design/bridge_regs.sv ====
// bridge register block
// debug border flag and the bridge read data mux

`timescale 1ns/1ps
`default_nettype none

module bridge_regs (
    input  wire             clk_74a,
    input  wire             reset_n,
    input  wire  [31:0]     bridge_addr,
    input  wire             bridge_rd,
    input  wire             bridge_wr,
    input  wire  [31:0]     bridge_wr_data,
    output logic [31:0]     bridge_rd_data,
    output logic            border_en
);

    import video_pkg::*;

    logic border_hit;

    // bridge address map, single entry
    assign border_hit = (bridge_addr == BORDER_REG_ADDR);

    // border on out of reset
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            border_en <= 1'b1;
        end else if (bridge_wr && border_hit) begin
            border_en <= bridge_wr_data[0];
        end
    end

    // read data follows the address combinationally,
    // bridge_rd only marks when the host samples it
    always_comb begin
        bridge_rd_data = '0;
        if (border_hit) begin
            bridge_rd_data = {31'b0, border_en};
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_composer.sv ====
// pixel composer
// layers background, debug border and square, registers rgb

`timescale 1ns/1ps
`default_nettype none

module pixel_composer #(
    parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE
) (
    input  wire                 clk_74a,
    input  wire                 reset_n,
    input  wire                 active,
    input  wire                 border_en,
    input  wire                 square_edge,
    input  wire                 square_fill,
    input  video_pkg::coord_t   visible_x,
    input  video_pkg::coord_t   visible_y,
    input  video_pkg::rgb_t     fill_rgb,
    output video_pkg::rgb_t     video_rgb
);

    import video_pkg::*;

    localparam coord_t X_LAST = coord_t'(H_ACTIVE - 1);
    localparam coord_t Y_LAST = coord_t'(V_ACTIVE - 1);

    rgb_t pix_next;

    always_comb begin
        // xor background
        pix_next = {visible_x[7:0], visible_y[7:0], visible_x[7:0] ^ visible_y[7:0]};

        // debug border, left/right take the corners
        if (border_en) begin
            if (visible_x == '0) begin
                pix_next = COLOR_WHITE;
            end else if (visible_x == X_LAST) begin
                pix_next = COLOR_GREEN;
            end else if (visible_y == '0) begin
                pix_next = COLOR_RED;
            end else if (visible_y == Y_LAST) begin
                pix_next = COLOR_BLUE;
            end
        end

        // square on top of everything
        if (square_edge) begin
            pix_next = COLOR_BLACK;
        end else if (square_fill) begin
            pix_next = fill_rgb;
        end
    end

    // aligned with video_de, black in blanking
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= COLOR_BLACK;
        end else begin
            video_rgb <= active ? pix_next : COLOR_BLACK;
        end
    end

endmodule

`default_nettype wire

// ==== design/square_sprite.sv ====
// d-pad driven square
// synchronizes the controller keys, moves the square once per
// frame within the active area and reports edge/fill hits

`timescale 1ns/1ps
`default_nettype none

module square_sprite #(
    parameter int H_ACTIVE    = video_pkg::DEF_H_ACTIVE,
    parameter int V_ACTIVE    = video_pkg::DEF_V_ACTIVE,
    parameter int SQUARE_SIZE = video_pkg::DEF_SQUARE_SIZE
) (
    input  wire                 clk_74a,
    input  wire                 reset_n,
    input  video_pkg::key_t     cont1_key,
    input  wire                 frame_start,
    input  video_pkg::coord_t   visible_x,
    input  video_pkg::coord_t   visible_y,
    output logic                square_edge,
    output logic                square_fill,
    output video_pkg::rgb_t     fill_rgb
);

    import video_pkg::*;

    localparam coord_t SQ_SIZE = coord_t'(SQUARE_SIZE);
    localparam coord_t X_MAX   = coord_t'(H_ACTIVE - SQUARE_SIZE);
    localparam coord_t Y_MAX   = coord_t'(V_ACTIVE - SQUARE_SIZE);
    // start centred
    localparam coord_t X_INIT  = coord_t'((H_ACTIVE - SQUARE_SIZE) / 2);
    localparam coord_t Y_INIT  = coord_t'((V_ACTIVE - SQUARE_SIZE) / 2);
    localparam coord_t ONE     = coord_t'(1);
    localparam coord_t ZERO    = coord_t'(0);

    key_t   key_meta;
    key_t   key_sync;
    coord_t sq_x;
    coord_t sq_y;
    coord_t next_x;
    coord_t next_y;
    logic   in_outer;
    logic   in_inner;

    ////////////////////////////////////////////////////////////
    // keys arrive asynchronously, two flop synchronizer

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= cont1_key;
            key_sync <= key_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // position update

    // each direction tested against the current corner,
    // so up+down or left+right cancel away from the limits
    always_comb begin
        next_x = sq_x;
        next_y = sq_y;
        if (key_sync[KEY_UP] && (sq_y > ZERO)) begin
            next_y = next_y - ONE;
        end
        if (key_sync[KEY_DOWN] && (sq_y < Y_MAX)) begin
            next_y = next_y + ONE;
        end
        if (key_sync[KEY_LEFT] && (sq_x > ZERO)) begin
            next_x = next_x - ONE;
        end
        if (key_sync[KEY_RIGHT] && (sq_x < X_MAX)) begin
            next_x = next_x + ONE;
        end
    end

    // frame_start lands before the first active pixel,
    // whole frame drawn from one position
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            sq_x <= X_INIT;
            sq_y <= Y_INIT;
        end else if (frame_start) begin
            sq_x <= next_x;
            sq_y <= next_y;
        end
    end

    ////////////////////////////////////////////////////////////
    // hit test against the counter-stage coordinates

    assign in_outer = (visible_x >= sq_x) && (visible_x < sq_x + SQ_SIZE) &&
                      (visible_y >= sq_y) && (visible_y < sq_y + SQ_SIZE);

    // one pixel in from every side
    assign in_inner = (visible_x >= sq_x + ONE) && (visible_x < sq_x + SQ_SIZE - ONE) &&
                      (visible_y >= sq_y + ONE) && (visible_y < sq_y + SQ_SIZE - ONE);

    assign square_fill = in_inner;
    // remaining outer ring
    assign square_edge = in_outer && !in_inner;

    // A beats B, white when neither held
    assign fill_rgb = key_sync[KEY_FACE_A] ? COLOR_MAGENTA :
                      key_sync[KEY_FACE_B] ? COLOR_GREEN   : COLOR_WHITE;

endmodule

`default_nettype wire

// ==== design/video_timing.sv ====
// raster timing generator
// x/y counters, active window, visible coordinates and
// registered de/hs/vs outputs

`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_BPORCH = video_pkg::DEF_H_BPORCH,
    parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter int H_TOTAL  = video_pkg::DEF_H_TOTAL,
    parameter int V_BPORCH = video_pkg::DEF_V_BPORCH,
    parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
    parameter int V_TOTAL  = video_pkg::DEF_V_TOTAL
) (
    input  wire                 clk_74a,
    input  wire                 reset_n,
    output video_pkg::coord_t   visible_x,
    output video_pkg::coord_t   visible_y,
    output logic                active,
    output logic                video_de,
    output logic                video_hs,
    output logic                video_vs,
    output logic                frame_start
);

    import video_pkg::*;

    // window edges in counter space
    localparam coord_t H_START = coord_t'(H_BPORCH);
    localparam coord_t H_END   = coord_t'(H_BPORCH + H_ACTIVE);
    localparam coord_t H_LAST  = coord_t'(H_TOTAL - 1);
    localparam coord_t V_START = coord_t'(V_BPORCH);
    localparam coord_t V_END   = coord_t'(V_BPORCH + V_ACTIVE);
    localparam coord_t V_LAST  = coord_t'(V_TOTAL - 1);
    localparam coord_t HS_POS  = coord_t'(HS_X);

    coord_t x_count;
    coord_t y_count;

    ////////////////////////////////////////////////////////////
    // counter stage

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            x_count <= x_count + coord_t'(1);
            if (x_count == H_LAST) begin
                x_count <= '0;
                // next line on every x wrap
                y_count <= y_count + coord_t'(1);
                if (y_count == V_LAST) begin
                    y_count <= '0;
                end
            end
        end
    end

    // inside both back porch edges
    assign active = (x_count >= H_START) && (x_count < H_END) &&
                    (y_count >= V_START) && (y_count < V_END);

    // porch-relative, negative before the window opens
    assign visible_x = x_count - H_START;
    assign visible_y = y_count - V_START;

    ////////////////////////////////////////////////////////////
    // output stage, one clock behind the counters

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end else begin
            video_de <= active;
            // line start pulse
            video_hs <= (x_count == HS_POS);
            // frame start pulse, top-left corner of the raster
            video_vs <= (x_count == '0) && (y_count == '0);
        end
    end

    // sprite steps on the vsync pulse itself
    assign frame_start = video_vs;

endmodule

`default_nettype wire

// ==== design/video_pkg.sv ====
// video test-pattern core shared definitions
// widths, default geometry, key bits, colours and the bridge map

`default_nettype none

package video_pkg;

    // signed screen coordinate, room for porch offsets below zero
    typedef logic signed [10:0] coord_t;

    // red [23:16], green [15:8], blue [7:0]
    typedef logic [23:0] rgb_t;

    // controller key bitmap as delivered by the bridge
    typedef logic [15:0] key_t;

    // key bit positions
    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_FACE_A = 4;
    localparam int KEY_FACE_B = 5;

    ////////////////////////////////////////////////////////////
    // default mode, 320x288 inside a 400x512 raster
    localparam int DEF_H_BPORCH    = 10;
    localparam int DEF_H_ACTIVE    = 320;
    localparam int DEF_H_TOTAL     = 400;
    localparam int DEF_V_BPORCH    = 10;
    localparam int DEF_V_ACTIVE    = 288;
    localparam int DEF_V_TOTAL     = 512;
    localparam int DEF_SQUARE_SIZE = 50;

    // hsync a few clocks into the line, clear of vsync
    localparam int HS_X = 3;

    localparam rgb_t COLOR_BLACK   = 24'h000000;
    localparam rgb_t COLOR_WHITE   = 24'hFFFFFF;
    localparam rgb_t COLOR_RED     = 24'hFF0000;
    localparam rgb_t COLOR_GREEN   = 24'h00FF00;
    localparam rgb_t COLOR_BLUE    = 24'h0000FF;
    localparam rgb_t COLOR_MAGENTA = 24'hFF00FF;

    // debug border flag register
    localparam logic [31:0] BORDER_REG_ADDR = 32'h50000000;

endpackage

`default_nettype wire
